// File: hw/pulp_pkg.sv
`default_nettype none

package pulp_pkg;

  // bus widths
  localparam int unsigned AXI_AW = 32;
  localparam int unsigned AXI_DW = 64;
  localparam int unsigned AXI_SW = AXI_DW / 8;

  // wide host ids, narrow ids behind the remapper
  localparam int unsigned HOST_IW = 4;
  localparam int unsigned BUS_IW  = 2;

  // address map
  localparam logic [AXI_AW-1:0] L2_BASE_ADDR  = 32'h1C00_0000;
  localparam logic [AXI_AW-1:0] EXT_BASE_ADDR = 32'h8000_0000;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  typedef enum logic [1:0] {
    ROUTE_L2,
    ROUTE_EXT,
    ROUTE_ERR
  } route_e;

  // single-beat request and response, host side
  typedef struct packed {
    logic [HOST_IW-1:0] id;
    op_e                op;
    logic [AXI_AW-1:0]  addr;
    logic [AXI_DW-1:0]  wdata;
    logic [AXI_SW-1:0]  strb;
  } host_req_t;

  typedef struct packed {
    logic [HOST_IW-1:0] id;
    logic [AXI_DW-1:0]  rdata;
    logic               err;
  } host_rsp_t;

  // same beats with the remapped id
  typedef struct packed {
    logic [BUS_IW-1:0] id;
    op_e               op;
    logic [AXI_AW-1:0] addr;
    logic [AXI_DW-1:0] wdata;
    logic [AXI_SW-1:0] strb;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_IW-1:0] id;
    logic [AXI_DW-1:0] rdata;
    logic              err;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: hw/axi_id_remap.sv
`timescale 1ns/1ps
`default_nettype none

module axi_id_remap #(
  parameter int unsigned TABLE_SIZE = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  input  wire logic                host_req_valid_i,
  input  wire pulp_pkg::host_req_t host_req_i,
  output logic                     host_req_ready_o,
  output logic                     host_rsp_valid_o,
  output pulp_pkg::host_rsp_t      host_rsp_o,
  input  wire logic                host_rsp_ready_i,

  output logic                     bus_req_valid_o,
  output pulp_pkg::bus_req_t       bus_req_o,
  input  wire logic                bus_req_ready_i,
  input  wire logic                bus_rsp_valid_i,
  input  wire pulp_pkg::bus_rsp_t  bus_rsp_i,
  output logic                     bus_rsp_ready_o
);

  import pulp_pkg::*;

  // per-slot state
  logic [TABLE_SIZE-1:0] occupied_q;
  logic [HOST_IW-1:0]    host_id_q [TABLE_SIZE];

  logic              free_found;
  logic [BUS_IW-1:0] free_idx;
  logic              req_fire;
  logic              rsp_fire;

  // lowest free slot wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_found = 1'b1;
        free_idx   = BUS_IW'(i);
      end
    end
  end

  assign host_req_ready_o = free_found && bus_req_ready_i;
  assign bus_req_valid_o  = host_req_valid_i && free_found;
  assign req_fire         = host_req_valid_i && host_req_ready_o;

  always_comb begin
    bus_req_o.id    = free_idx;
    bus_req_o.op    = host_req_i.op;
    bus_req_o.addr  = host_req_i.addr;
    bus_req_o.wdata = host_req_i.wdata;
    bus_req_o.strb  = host_req_i.strb;
  end

  // response path is a straight pass with the id swapped back
  assign host_rsp_valid_o = bus_rsp_valid_i;
  assign bus_rsp_ready_o  = host_rsp_ready_i;
  assign rsp_fire         = bus_rsp_valid_i && host_rsp_ready_i;

  always_comb begin
    host_rsp_o.id    = host_id_q[bus_rsp_i.id];
    host_rsp_o.rdata = bus_rsp_i.rdata;
    host_rsp_o.err   = bus_rsp_i.err;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      occupied_q <= '0;
    end else begin
      // set and clear never hit the same slot in one cycle
      if (req_fire) begin
        occupied_q[free_idx] <= 1'b1;
      end
      if (rsp_fire) begin
        occupied_q[bus_rsp_i.id] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      host_id_q[free_idx] <= host_req_i.id;
    end
  end

  // the bus must only answer ids that were handed out
  a_rsp_slot_used : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus_rsp_valid_i |-> occupied_q[bus_rsp_i.id]
  ) else $error("response for a free remap slot");

endmodule

`default_nettype wire

// File: hw/soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus #(
  parameter int unsigned L2_N_BYTES = 4096,
  parameter int unsigned MAX_TXNS   = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,

  input  wire logic               up_req_valid_i,
  input  wire pulp_pkg::bus_req_t up_req_i,
  output logic                    up_req_ready_o,
  output logic                    up_rsp_valid_o,
  output pulp_pkg::bus_rsp_t      up_rsp_o,
  input  wire logic               up_rsp_ready_i,

  output logic                    l2_req_valid_o,
  output pulp_pkg::bus_req_t      l2_req_o,
  input  wire logic               l2_req_ready_i,
  input  wire logic               l2_rsp_valid_i,
  input  wire pulp_pkg::bus_rsp_t l2_rsp_i,
  output logic                    l2_rsp_ready_o,

  output logic                    ext_req_valid_o,
  output pulp_pkg::bus_req_t      ext_req_o,
  input  wire logic               ext_req_ready_i,
  input  wire logic               ext_rsp_valid_i,
  input  wire pulp_pkg::bus_rsp_t ext_rsp_i,
  output logic                    ext_rsp_ready_o
);

  import pulp_pkg::*;

  localparam int unsigned PTR_W = (MAX_TXNS > 1) ? $clog2(MAX_TXNS) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_TXNS + 1);

  typedef struct packed {
    route_e            route;
    logic [BUS_IW-1:0] id;
  } entry_t;

  entry_t            queue_q [MAX_TXNS];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              full, empty, push, pop;
  logic [AXI_AW-1:0] l2_offset;
  route_e            route;
  entry_t            head;
  logic              l2_pend, ext_pend;

  // unsigned wrap keeps the l2 decode to one compare
  always_comb begin
    l2_offset = up_req_i.addr - L2_BASE_ADDR;
    if (l2_offset < AXI_AW'(L2_N_BYTES)) begin
      route = ROUTE_L2;
    end else if (up_req_i.addr >= EXT_BASE_ADDR) begin
      route = ROUTE_EXT;
    end else begin
      route = ROUTE_ERR;
    end
  end

  assign full  = (count_q == CNT_W'(MAX_TXNS));
  assign empty = (count_q == '0);
  assign head  = queue_q[rd_ptr_q];

  // request side
  assign l2_req_o        = up_req_i;
  assign ext_req_o       = up_req_i;
  assign l2_req_valid_o  = up_req_valid_i && !full && (route == ROUTE_L2);
  assign ext_req_valid_o = up_req_valid_i && !full && (route == ROUTE_EXT);
  assign up_req_ready_o  = !full && ((route == ROUTE_L2)  ? l2_req_ready_i  :
                                     (route == ROUTE_EXT) ? ext_req_ready_i : 1'b1);
  assign push = up_req_valid_i && up_req_ready_o;

  // response side follows the queue head only
  always_comb begin
    up_rsp_valid_o  = 1'b0;
    up_rsp_o        = '{id: head.id, rdata: '0, err: 1'b1};
    l2_rsp_ready_o  = 1'b0;
    ext_rsp_ready_o = 1'b0;
    if (!empty) begin
      case (head.route)
        ROUTE_L2: begin
          up_rsp_valid_o = l2_rsp_valid_i;
          up_rsp_o       = l2_rsp_i;
          l2_rsp_ready_o = up_rsp_ready_i;
        end
        ROUTE_EXT: begin
          up_rsp_valid_o  = ext_rsp_valid_i;
          up_rsp_o        = ext_rsp_i;
          ext_rsp_ready_o = up_rsp_ready_i;
        end
        // decode error answered locally
        default: up_rsp_valid_o = 1'b1;
      endcase
    end
  end

  assign pop = up_rsp_valid_o && up_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TXNS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TXNS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{route: route, id: up_req_i.id};
    end
  end

  // which targets own an entry somewhere in the queue
  always_comb begin
    int idx;
    l2_pend  = 1'b0;
    ext_pend = 1'b0;
    for (int k = 0; k < MAX_TXNS; k++) begin
      idx = (int'(rd_ptr_q) + k) % MAX_TXNS;
      if (k < int'(count_q)) begin
        l2_pend  = l2_pend  || (queue_q[idx].route == ROUTE_L2);
        ext_pend = ext_pend || (queue_q[idx].route == ROUTE_EXT);
      end
    end
  end

  // occupancy count agrees with the distance between the pointers
  a_queue_bounds : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (count_q <= CNT_W'(MAX_TXNS)) &&
    (int'(wr_ptr_q) == (int'(rd_ptr_q) + int'(count_q)) % MAX_TXNS)
  ) else $error("route queue overflow or underflow");

  // a target may only answer while it holds an outstanding entry
  a_rsp_routed : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (l2_rsp_valid_i |-> l2_pend) and (ext_rsp_valid_i |-> ext_pend)
  ) else $error("target response without a matching route entry");

endmodule

`default_nettype wire

// File: hw/l2_mem.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem #(
  parameter int unsigned L2_N_BYTES = 4096
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               req_valid_i,
  input  wire pulp_pkg::bus_req_t req_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output pulp_pkg::bus_rsp_t      rsp_o,
  input  wire logic               rsp_ready_i
);

  import pulp_pkg::*;

  localparam int unsigned N_WORDS = L2_N_BYTES / AXI_SW;
  localparam int unsigned LSB     = $clog2(AXI_SW);
  localparam int unsigned MSB     = $clog2(L2_N_BYTES) - 1;

  logic [AXI_DW-1:0]  mem_q [N_WORDS];
  logic               rsp_valid_q;
  bus_rsp_t           rsp_q;
  logic [MSB-LSB:0]   word_idx;
  logic               req_fire;

  // word offset inside the region
  assign word_idx    = req_i.addr[MSB:LSB];
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.id  <= req_i.id;
      rsp_q.err <= 1'b0;
      if (req_i.op == OP_WRITE) begin
        // byte merge under strobe, writes answer with zero data
        for (int b = 0; b < AXI_SW; b++) begin
          if (req_i.strb[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
        rsp_q.rdata <= '0;
      end else begin
        rsp_q.rdata <= mem_q[word_idx];
      end
    end
  end

  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
  ) else $error("l2 response changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/pulp_soc.sv
`timescale 1ns/1ps
`default_nettype none

module pulp_soc #(
  parameter int unsigned L2_N_BYTES = 4096,
  parameter int unsigned TABLE_SIZE = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  // host slave port
  input  wire logic                host_req_valid_i,
  input  wire pulp_pkg::host_req_t host_req_i,
  output logic                     host_req_ready_o,
  output logic                     host_rsp_valid_o,
  output pulp_pkg::host_rsp_t      host_rsp_o,
  input  wire logic                host_rsp_ready_i,

  // external master port
  output logic                     ext_req_valid_o,
  output pulp_pkg::bus_req_t       ext_req_o,
  input  wire logic                ext_req_ready_i,
  input  wire logic                ext_rsp_valid_i,
  input  wire pulp_pkg::bus_rsp_t  ext_rsp_i,
  output logic                     ext_rsp_ready_o
);

  import pulp_pkg::*;

  // remapper to bus
  logic     bus_req_valid, bus_req_ready, bus_rsp_valid, bus_rsp_ready;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  // bus to l2
  logic     l2_req_valid, l2_req_ready, l2_rsp_valid, l2_rsp_ready;
  bus_req_t l2_req;
  bus_rsp_t l2_rsp;

  axi_id_remap #(
    .TABLE_SIZE (TABLE_SIZE)
  ) i_id_remap (
    .clk_i,
    .rst_n_i,
    .host_req_valid_i,
    .host_req_i,
    .host_req_ready_o,
    .host_rsp_valid_o,
    .host_rsp_o,
    .host_rsp_ready_i,
    .bus_req_valid_o (bus_req_valid),
    .bus_req_o       (bus_req),
    .bus_req_ready_i (bus_req_ready),
    .bus_rsp_valid_i (bus_rsp_valid),
    .bus_rsp_i       (bus_rsp),
    .bus_rsp_ready_o (bus_rsp_ready)
  );

  soc_bus #(
    .L2_N_BYTES (L2_N_BYTES),
    .MAX_TXNS   (TABLE_SIZE)
  ) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .up_req_valid_i  (bus_req_valid),
    .up_req_i        (bus_req),
    .up_req_ready_o  (bus_req_ready),
    .up_rsp_valid_o  (bus_rsp_valid),
    .up_rsp_o        (bus_rsp),
    .up_rsp_ready_i  (bus_rsp_ready),
    .l2_req_valid_o  (l2_req_valid),
    .l2_req_o        (l2_req),
    .l2_req_ready_i  (l2_req_ready),
    .l2_rsp_valid_i  (l2_rsp_valid),
    .l2_rsp_i        (l2_rsp),
    .l2_rsp_ready_o  (l2_rsp_ready),
    .ext_req_valid_o,
    .ext_req_o,
    .ext_req_ready_i,
    .ext_rsp_valid_i,
    .ext_rsp_i,
    .ext_rsp_ready_o
  );

  l2_mem #(
    .L2_N_BYTES (L2_N_BYTES)
  ) i_l2_mem (
    .clk_i,
    .rst_n_i,
    .req_valid_i (l2_req_valid),
    .req_i       (l2_req),
    .req_ready_o (l2_req_ready),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_o       (l2_rsp),
    .rsp_ready_i (l2_rsp_ready)
  );

endmodule

`default_nettype wire

// File: bench/tb_pulp_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pulp_soc;

  import pulp_pkg::*;

  localparam int unsigned L2_N_BYTES     = 4096;
  localparam int unsigned TABLE_SIZE     = 4;
  localparam int unsigned TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED           = 32'h5244_f87a;
  localparam logic [63:0] EXT_XOR        = 64'hA5A5_0000_5A5A_FFFF;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      host_req_valid_i;
  host_req_t host_req_i;
  logic      host_req_ready_o;
  logic      host_rsp_valid_o;
  host_rsp_t host_rsp_o;
  logic      host_rsp_ready_i;
  logic      ext_req_valid_o;
  bus_req_t  ext_req_o;
  logic      ext_req_ready_i;
  logic      ext_rsp_valid_i;
  bus_rsp_t  ext_rsp_i;
  logic      ext_rsp_ready_o;

  // scoreboard and model state
  logic [7:0]  l2_model [L2_N_BYTES];
  host_rsp_t   exp_q [$];
  bus_req_t    ext_exp_q [$];
  bus_req_t    ext_pend_q [$];
  int unsigned pool [8];
  logic [31:0] test_st, ext_st, bp_st;
  int          outstanding = 0;
  int          cycles = 0;
  logic        started, rsp_hold, bp_en;
  logic        rsp_wait = 1'b0;
  host_rsp_t   rsp_last;

  pulp_soc #(
    .L2_N_BYTES (L2_N_BYTES),
    .TABLE_SIZE (TABLE_SIZE)
  ) uut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    test_st = xorshift32(test_st);
    return test_st;
  endfunction

  task automatic value_error(input string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic run_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
      run_error($sformatf("simulation did not finish within %0d cycles", cycles));
  end

  // expected response from the address map and the L2 model in issue order
  task automatic send(input logic [HOST_IW-1:0] id, input op_e op, input logic [31:0] addr,
                      input logic [63:0] wdata, input logic [7:0] strb);
    host_rsp_t   e;
    logic [31:0] off;
    int          base;
    e   = '{id: id, rdata: '0, err: 1'b0};
    off = addr - L2_BASE_ADDR;
    if (addr >= L2_BASE_ADDR && addr < L2_BASE_ADDR + L2_N_BYTES) begin
      base = int'({off[31:3], 3'b000});
      for (int b = 0; b < 8; b++) begin
        if (op == OP_WRITE && strb[b])
          l2_model[base + b] = wdata[b*8 +: 8];
        else if (op == OP_READ)
          e.rdata[b*8 +: 8] = l2_model[base + b];
      end
    end else if (addr >= EXT_BASE_ADDR) begin
      e.rdata = (op == OP_READ) ? ({32'h0, addr} ^ EXT_XOR) : '0;
      ext_exp_q.push_back('{id: '0, op: op, addr: addr, wdata: wdata, strb: strb});
    end else begin
      e.err = 1'b1;
    end
    exp_q.push_back(e);
    started          = 1'b1;
    host_req_i       = '{id: id, op: op, addr: addr, wdata: wdata, strb: strb};
    host_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!host_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    host_req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  // host response checks sampled half a cycle away from the driving edge
  always @(negedge clk_i) begin
    host_rsp_t exp;
    if (rst_n_i) begin
      if (!started) begin
        assert (!host_rsp_valid_o && !ext_req_valid_o)
          else value_error("valid output raised before the first request");
      end
      if (outstanding == TABLE_SIZE) begin
        assert (!host_req_ready_o) else value_error("host_req_ready_o high with table full");
      end
      if (rsp_wait) begin
        assert (host_rsp_valid_o && host_rsp_o === rsp_last)
          else value_error("host response changed while stalled");
      end
      if (host_req_valid_i && host_req_ready_o)
        outstanding++;
      if (host_rsp_valid_o && host_rsp_ready_i) begin
        assert (exp_q.size() != 0) else run_error("host response arrived with none pending");
        exp = exp_q.pop_front();
        assert (host_rsp_o === exp) else value_error($sformatf(
          "rsp id %h data %h err %b, expected id %h data %h err %b", host_rsp_o.id,
          host_rsp_o.rdata, host_rsp_o.err, exp.id, exp.rdata, exp.err));
        outstanding--;
      end
      rsp_wait = host_rsp_valid_o && !host_rsp_ready_i;
      rsp_last = host_rsp_o;
    end
  end

  always @(negedge clk_i) begin
    bus_req_t exp;
    if (rst_n_i && ext_req_valid_o && ext_req_ready_i) begin
      assert (ext_exp_q.size() != 0) else run_error("external port got a request not routed there");
      exp = ext_exp_q.pop_front();
      assert (ext_req_o.op == exp.op && ext_req_o.addr == exp.addr &&
              ext_req_o.wdata == exp.wdata && ext_req_o.strb == exp.strb)
        else value_error($sformatf("ext req addr %h op %0d, expected addr %h op %0d",
          ext_req_o.addr, ext_req_o.op, exp.addr, exp.op));
      ext_pend_q.push_back(ext_req_o);
    end
  end

  // external target answers in order after 0 to 5 idle cycles
  initial begin : ext_target
    bus_req_t    r;
    int unsigned d;
    ext_st          = SEED;
    ext_req_ready_i = 1'b1;
    ext_rsp_valid_i = 1'b0;
    ext_rsp_i       = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ext_pend_q.size() != 0) begin
        r      = ext_pend_q.pop_front();
        ext_st = xorshift32(ext_st);
        d      = ext_st % 6;
        repeat (d) begin
          @(posedge clk_i);
          #1;
        end
        ext_rsp_i.id    = r.id;
        ext_rsp_i.rdata = (r.op == OP_READ) ? ({32'h0, r.addr} ^ EXT_XOR) : '0;
        ext_rsp_i.err   = 1'b0;
        ext_rsp_valid_i = 1'b1;
        @(negedge clk_i);
        while (!ext_rsp_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ext_rsp_valid_i = 1'b0;
      end
    end
  end

  initial begin : rsp_ready_driver
    bp_st            = SEED ^ 32'h1357_9bdf;
    host_rsp_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      bp_st = xorshift32(bp_st);
      if (rsp_hold) begin
        host_rsp_ready_i = 1'b0;
      end else if (!bp_en) begin
        host_rsp_ready_i = 1'b1;
      end else if (bp_st[1:0] == 2'b00) begin
        // flips about one cycle in four so stalls come in stretches
        host_rsp_ready_i = !host_rsp_ready_i;
      end
    end
  end

  task automatic check_reset_state();
    repeat (5) @(posedge clk_i);
    #1;
    assert (!host_rsp_valid_o && !ext_req_valid_o)
      else value_error("response or external request valid after reset");
  endtask

  task automatic l2_write_read();
    logic [31:0] r;
    logic [31:0] a;
    // full-word fill first with a pattern taken from the byte address
    for (int i = 0; i < 8; i++) begin
      pool[i] = next_rand() % (L2_N_BYTES / 8);
      a       = L2_BASE_ADDR + pool[i] * 8;
      send(4'(i), OP_WRITE, a, {~a, a}, 8'hFF);
    end
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      a = L2_BASE_ADDR + pool[r[2:0]] * 8;
      send(r[7:4], OP_WRITE, a, {next_rand(), next_rand()}, r[15:8]);
    end
    for (int i = 0; i < 8; i++)
      send(4'(15 - i), OP_READ, L2_BASE_ADDR + pool[i] * 8, '0, '0);
    drain();
  endtask

  task automatic decode_error();
    send(4'h3, OP_READ, 32'h0000_1000, '0, '0);
    // aliases pool word 0 in the low bits and must not reach L2
    send(4'h9, OP_WRITE, L2_BASE_ADDR + L2_N_BYTES + pool[0] * 8, '1, 8'hFF);
    send(4'hC, OP_WRITE, EXT_BASE_ADDR - 8, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF);
    send(4'h5, OP_READ, L2_BASE_ADDR + pool[0] * 8, '0, '0);
    drain();
  endtask

  task automatic ext_forwarding();
    logic [31:0] r;
    logic [31:0] a;
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      a = EXT_BASE_ADDR | (next_rand() & 32'h7FFF_FFF8);
      send(r[3:0], r[4] ? OP_WRITE : OP_READ, a, {next_rand(), r}, r[15:8]);
    end
    send(4'hF, OP_READ, 32'hFFFF_FFF8, '0, '0);
    drain();
  endtask

  task automatic ordering_limit();
    logic [31:0] a;
    @(negedge clk_i);
    rsp_hold = 1'b1;
    @(posedge clk_i);
    #1;
    send(4'h0, OP_READ, L2_BASE_ADDR + pool[1] * 8, '0, '0);
    send(4'h1, OP_READ, EXT_BASE_ADDR + 32'h40, '0, '0);
    send(4'h2, OP_WRITE, EXT_BASE_ADDR + 32'h48, 64'h0123_4567_89AB_CDEF, 8'h0F);
    send(4'h3, OP_READ, 32'h4000_0000, '0, '0);
    repeat (3) begin
      @(negedge clk_i);
      assert (!host_req_ready_o) else value_error("request ready with four outstanding");
    end
    rsp_hold = 1'b0;
    while (!(host_rsp_valid_o && host_rsp_ready_i)) @(negedge clk_i);
    @(negedge clk_i);
    assert (host_req_ready_o) else value_error("request ready stayed low after a response");
    @(posedge clk_i);
    #1;
    for (int i = 4; i < 16; i++) begin
      a = EXT_BASE_ADDR + 32'(i) * 8;
      case (i % 4)
        0: send(4'(i), OP_READ, L2_BASE_ADDR + pool[i % 8] * 8, '0, '0);
        1: send(4'(i), OP_READ, a, '0, '0);
        2: send(4'(i), OP_WRITE, 32'h2000_0000 + 32'(i), '0, 8'h01);
        default: send(4'(i), OP_WRITE, a, {next_rand(), next_rand()}, 8'hF0);
      endcase
    end
    drain();
  endtask

  task automatic rsp_backpressure();
    logic [31:0] r;
    @(negedge clk_i);
    bp_en = 1'b1;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0: send(r[7:4], OP_READ, L2_BASE_ADDR + pool[r[10:8]] * 8, '0, '0);
        2'd1: send(r[7:4], OP_WRITE, L2_BASE_ADDR + pool[r[10:8]] * 8, {r, ~r}, r[23:16]);
        2'd2: send(r[7:4], r[2] ? OP_WRITE : OP_READ,
                   EXT_BASE_ADDR + {9'h0, r[31:12], 3'b000}, {~r, r}, r[23:16]);
        default: send(r[7:4], OP_READ, 32'h0800_0000 + {13'h0, r[27:12], 3'b000}, '0, '0);
      endcase
    end
    drain();
    @(negedge clk_i);
    bp_en = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  initial begin : main
    rst_n_i          = 1'b0;
    host_req_valid_i = 1'b0;
    host_req_i       = '0;
    started          = 1'b0;
    rsp_hold         = 1'b0;
    bp_en            = 1'b0;
    test_st          = ~SEED;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_reset_state();
    l2_write_read();
    decode_error();
    ext_forwarding();
    ordering_limit();
    rsp_backpressure();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/pulp_pkg.sv
hw/axi_id_remap.sv
hw/soc_bus.sv
hw/l2_mem.sv
hw/pulp_soc.sv
bench/tb_pulp_soc.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_pulp_soc
BUILD_DIR ?= build
FILELIST  ?= project.f

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when the file list or a source is newer than the binary
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
